// ==== src/mul_pkg.sv ====
/*
 * Shared definitions for the multiply unit.
 * Holds the operation codes, datapath widths, the operand view
 * and the sequencer state encoding. Modules refer to them by scope.
 */

package mul_pkg;

        ////////////////////////////////////////////////////////////
        // Operation codes
        ////////////////////////////////////////////////////////////

        localparam int OP_W = 5;

        localparam logic [OP_W-1:0] OP_NONE     = 5'd0;

        // Long multiply, issued as a LO then HI pair
        localparam logic [OP_W-1:0] OP_UMULL_LO = 5'd1;
        localparam logic [OP_W-1:0] OP_UMULL_HI = 5'd2;
        localparam logic [OP_W-1:0] OP_SMULL_LO = 5'd3;
        localparam logic [OP_W-1:0] OP_SMULL_HI = 5'd4;

        // Halfword multiply, first digit Rm half and second digit Rs half
        localparam logic [OP_W-1:0] OP_SMUL00   = 5'd5;
        localparam logic [OP_W-1:0] OP_SMUL01   = 5'd6;
        localparam logic [OP_W-1:0] OP_SMUL10   = 5'd7;
        localparam logic [OP_W-1:0] OP_SMUL11   = 5'd8;

        // Halfword multiply-accumulate with overflow flag
        localparam logic [OP_W-1:0] OP_SMLA00   = 5'd9;
        localparam logic [OP_W-1:0] OP_SMLA01   = 5'd10;
        localparam logic [OP_W-1:0] OP_SMLA10   = 5'd11;
        localparam logic [OP_W-1:0] OP_SMLA11   = 5'd12;

        // Word by halfword, y picks the Rs half
        localparam logic [OP_W-1:0] OP_SMULW0   = 5'd13;
        localparam logic [OP_W-1:0] OP_SMULW1   = 5'd14;

        ////////////////////////////////////////////////////////////
        // Datapath widths
        ////////////////////////////////////////////////////////////

        localparam int WORD_W      = 32;
        localparam int HALF_W      = 16;
        localparam int PART_W      = 17;
        localparam int PROD_W      = 34;
        localparam int ACC_W       = 64;
        localparam int UPPER_SHIFT = 16;

        // One register word, seen whole or as two halves
        typedef union packed {
                logic [WORD_W-1:0] word;
                struct packed {
                        logic [HALF_W-1:0] hi;
                        logic [HALF_W-1:0] lo;
                } half;
        } operand_u;

        // Sequencer steps, one-hot
        typedef enum logic [4:0] {
                IDLE   = 5'b00001,
                LATCH  = 5'b00010,
                SUM_LO = 5'b00100,
                SUM_HI = 5'b01000,
                OUT    = 5'b10000
        } seq_state_t;

endpackage

// ==== src/mul_operand_decode.sv ====
/*
 * Operand decode for the multiply unit.
 * Splits Rm and Rs into 17-bit signed parts per operation and
 * registers them for the product array. The class flags stay
 * combinational for the sequencer and the accumulator.
 */

`timescale 1ns/10ps

module mul_operand_decode
(
        input  logic                              i_clk,
        input  logic [mul_pkg::OP_W-1:0]          i_op,
        input  logic [mul_pkg::WORD_W-1:0]        i_rm,
        input  logic [mul_pkg::WORD_W-1:0]        i_rs,

        output logic signed [mul_pkg::PART_W-1:0] o_a,
        output logic signed [mul_pkg::PART_W-1:0] o_b,
        output logic signed [mul_pkg::PART_W-1:0] o_c,
        output logic signed [mul_pkg::PART_W-1:0] o_d,
        output logic                              o_take_upper,
        output logic                              o_is_high,
        output logic                              o_is_mac,
        output logic                              o_is_mul
);

mul_pkg::operand_u           rm_u;
mul_pkg::operand_u           rs_u;
logic                        is_half;
logic                        is_wide;
logic                        is_signed_long;
logic                        rm_top;
logic                        rs_top;
logic [mul_pkg::HALF_W-1:0]  rm_half;
logic [mul_pkg::HALF_W-1:0]  rs_half;
logic [mul_pkg::PART_W-1:0]  a_nxt;
logic [mul_pkg::PART_W-1:0]  b_nxt;
logic [mul_pkg::PART_W-1:0]  c_nxt;
logic [mul_pkg::PART_W-1:0]  d_nxt;

////////////////////////////////////////////////////////////

always_comb
begin
        rm_u.word = i_rm;
        rs_u.word = i_rs;

        is_signed_long = (i_op == mul_pkg::OP_SMULL_LO) || (i_op == mul_pkg::OP_SMULL_HI);
        is_wide        = (i_op == mul_pkg::OP_SMULW0) || (i_op == mul_pkg::OP_SMULW1);
        o_is_mac       = (i_op >= mul_pkg::OP_SMLA00) && (i_op <= mul_pkg::OP_SMLA11);
        is_half        = ((i_op >= mul_pkg::OP_SMUL00) && (i_op <= mul_pkg::OP_SMUL11)) ||
                         o_is_mac;
        o_is_high      = (i_op == mul_pkg::OP_UMULL_HI) || (i_op == mul_pkg::OP_SMULL_HI);
        o_is_mul       = (i_op != mul_pkg::OP_NONE) && (i_op <= mul_pkg::OP_SMULW1);

        // Half selects, x for Rm and y for Rs
        rm_top = (i_op == mul_pkg::OP_SMUL10) || (i_op == mul_pkg::OP_SMUL11) ||
                 (i_op == mul_pkg::OP_SMLA10) || (i_op == mul_pkg::OP_SMLA11);
        rs_top = (i_op == mul_pkg::OP_SMUL01) || (i_op == mul_pkg::OP_SMUL11) ||
                 (i_op == mul_pkg::OP_SMLA01) || (i_op == mul_pkg::OP_SMLA11) ||
                 (i_op == mul_pkg::OP_SMULW1);

        rm_half = rm_top ? rm_u.half.hi : rm_u.half.lo;
        rs_half = rs_top ? rs_u.half.hi : rs_u.half.lo;

        // Unsigned long multiply unless a case below says otherwise
        a_nxt = {1'b0, rm_u.half.hi};
        c_nxt = {1'b0, rm_u.half.lo};
        b_nxt = {1'b0, rs_u.half.hi};
        d_nxt = {1'b0, rs_u.half.lo};

        if (is_signed_long)
        begin
                a_nxt = {rm_u.word[mul_pkg::WORD_W-1], rm_u.half.hi};
                b_nxt = {rs_u.word[mul_pkg::WORD_W-1], rs_u.half.hi};
        end
        else if (is_wide)
        begin
                // Full signed Rm against one signed Rs half
                a_nxt = {rm_u.word[mul_pkg::WORD_W-1], rm_u.half.hi};
                b_nxt = {mul_pkg::PART_W{rs_half[mul_pkg::HALF_W-1]}};
                d_nxt = {1'b0, rs_half};
        end
        else if (is_half)
        begin
                // Upper part is pure sign fill of the chosen half
                a_nxt = {mul_pkg::PART_W{rm_half[mul_pkg::HALF_W-1]}};
                c_nxt = {1'b0, rm_half};
                b_nxt = {mul_pkg::PART_W{rs_half[mul_pkg::HALF_W-1]}};
                d_nxt = {1'b0, rs_half};
        end
end

////////////////////////////////////////////////////////////

// Reloads every cycle from the held inputs
always_ff @(posedge i_clk)
begin
        o_a          <= a_nxt;
        o_b          <= b_nxt;
        o_c          <= c_nxt;
        o_d          <= d_nxt;
        o_take_upper <= is_wide;
end

endmodule

// ==== src/mul_product_array.sv ====
/*
 * Four signed 17x17 multipliers with an output register.
 * Maps onto DSP slices and yields the partial products
 * one cycle after the operand parts arrive.
 */

`timescale 1ns/10ps

module mul_product_array
(
        input  logic                              i_clk,
        input  logic signed [mul_pkg::PART_W-1:0] i_a,
        input  logic signed [mul_pkg::PART_W-1:0] i_b,
        input  logic signed [mul_pkg::PART_W-1:0] i_c,
        input  logic signed [mul_pkg::PART_W-1:0] i_d,

        output logic signed [mul_pkg::PROD_W-1:0] o_ab,
        output logic signed [mul_pkg::PROD_W-1:0] o_bc,
        output logic signed [mul_pkg::PROD_W-1:0] o_ad,
        output logic signed [mul_pkg::PROD_W-1:0] o_cd
);

////////////////////////////////////////////////////////////

// {a,c} is Rm and {b,d} is Rs, with c and d as unsigned low parts
always_ff @(posedge i_clk)
begin
        // High by high, weight 2^32
        o_ab <= i_a * i_b;

        // Cross terms, weight 2^16
        o_bc <= i_b * i_c;
        o_ad <= i_a * i_d;

        // Low by low
        o_cd <= i_c * i_d;
end

endmodule

// ==== src/mul_sequencer.sv ====
/*
 * Step control for the multiply unit.
 * A one-hot FSM walks each accepted operation through latch,
 * low sum, high sum and output. HI operations skip the sums.
 */

`timescale 1ns/10ps

module mul_sequencer
(
        input  logic i_clk,
        input  logic i_reset,
        input  logic i_stall,
        input  logic i_valid,
        input  logic i_is_mul,
        input  logic i_is_high,

        output logic o_step_lo,
        output logic o_step_hi,
        output logic o_step_out,
        output logic o_busy
);

mul_pkg::seq_state_t state_q;
mul_pkg::seq_state_t state_nxt;

////////////////////////////////////////////////////////////

always_comb
begin
        state_nxt = state_q;

        case (state_q)
                mul_pkg::IDLE:
                begin
                        if (i_valid && i_is_mul)
                        begin
                                state_nxt = mul_pkg::LATCH;
                        end
                end

                // Operands and products settle here
                mul_pkg::LATCH:
                begin
                        state_nxt = i_is_high ? mul_pkg::OUT : mul_pkg::SUM_LO;
                end

                mul_pkg::SUM_LO: state_nxt = mul_pkg::SUM_HI;

                mul_pkg::SUM_HI: state_nxt = mul_pkg::OUT;

                mul_pkg::OUT:    state_nxt = mul_pkg::IDLE;

                default:         state_nxt = mul_pkg::IDLE;
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q <= mul_pkg::IDLE;
        end
        else if (!i_stall)
        begin
                state_q <= state_nxt;
        end
end

////////////////////////////////////////////////////////////

// Strobes straight from the state bits
always_comb
begin
        o_step_lo  = (state_q == mul_pkg::SUM_LO);
        o_step_hi  = (state_q == mul_pkg::SUM_HI);
        o_step_out = (state_q == mul_pkg::OUT);
        o_busy     = (state_q == mul_pkg::LATCH) || o_step_lo || o_step_hi;
end

endmodule

// ==== src/mul_accumulate.sv ====
/*
 * Result stage of the multiply unit.
 * Sums the partial products and the addend into a 64-bit
 * accumulator, tracks halfword MAC overflow and the low-word
 * nonzero state, and selects the result word on the output step.
 */

`timescale 1ns/10ps

module mul_accumulate
(
        input  logic                              i_clk,
        input  logic                              i_reset,
        input  logic                              i_stall,
        input  logic                              i_step_lo,
        input  logic                              i_step_hi,
        input  logic                              i_step_out,
        input  logic                              i_is_high,
        input  logic                              i_is_mac,
        input  logic                              i_take_upper,

        input  logic signed [mul_pkg::PROD_W-1:0] i_ab,
        input  logic signed [mul_pkg::PROD_W-1:0] i_bc,
        input  logic signed [mul_pkg::PROD_W-1:0] i_ad,
        input  logic signed [mul_pkg::PROD_W-1:0] i_cd,

        input  logic [mul_pkg::WORD_W-1:0]        i_rn,
        input  logic [mul_pkg::WORD_W-1:0]        i_rh,

        output logic [mul_pkg::WORD_W-1:0]        o_rd,
        output logic                              o_sat,
        output logic                              o_nozero
);

logic signed [mul_pkg::ACC_W-1:0] acc_q;
logic signed [mul_pkg::ACC_W-1:0] lo_sum;
logic signed [mul_pkg::ACC_W-1:0] hi_sum;
logic signed [mul_pkg::ACC_W-1:0] shifted;
logic [mul_pkg::WORD_W-1:0]       rd_word;
logic                             ovf;
logic                             sat_q;
logic                             lo_nonzero_q;

// Widen a partial product to accumulator width
function automatic logic [mul_pkg::ACC_W-1:0] sext(input logic [mul_pkg::PROD_W-1:0] p);
        return {{(mul_pkg::ACC_W-mul_pkg::PROD_W){p[mul_pkg::PROD_W-1]}}, p};
endfunction

////////////////////////////////////////////////////////////

always_comb
begin
        lo_sum = sext(i_cd) + (sext(i_bc) << mul_pkg::HALF_W) +
                 (sext(i_ad) << mul_pkg::HALF_W);
        hi_sum = acc_q + (sext(i_ab) << mul_pkg::WORD_W) + {i_rh, i_rn};

        // Product and Rn agree in sign but the sum does not
        ovf = (acc_q[mul_pkg::WORD_W-1] == i_rn[mul_pkg::WORD_W-1]) &&
              (hi_sum[mul_pkg::WORD_W-1] != acc_q[mul_pkg::WORD_W-1]);
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                acc_q        <= '0;
                sat_q        <= 1'b0;
                lo_nonzero_q <= 1'b0;
        end
        else if (!i_stall)
        begin
                if (i_step_lo)
                begin
                        acc_q <= lo_sum;
                end

                if (i_step_hi)
                begin
                        acc_q <= hi_sum;
                        sat_q <= i_is_mac && ovf;
                end

                // Remembered for the zero override on the HI half
                if (i_step_out && !i_is_high)
                begin
                        lo_nonzero_q <= |rd_word;
                end
        end
end

////////////////////////////////////////////////////////////

always_comb
begin
        // SMULWy keeps bits 47..16
        if (i_take_upper)
        begin
                shifted = acc_q >>> mul_pkg::UPPER_SHIFT;
        end
        else
        begin
                shifted = acc_q;
        end

        rd_word  = i_is_high ? shifted[mul_pkg::ACC_W-1:mul_pkg::WORD_W]
                             : shifted[mul_pkg::WORD_W-1:0];

        o_rd     = i_step_out ? rd_word : '0;
        o_sat    = i_step_out && sat_q;
        o_nozero = i_step_out && i_is_high && lo_nonzero_q;
end

endmodule

// ==== src/mul_unit.sv ====
/*
 * Multi-cycle multiply unit top level.
 * Connects operand decode, the product array, the sequencer
 * and the accumulator. o_done pulses with the result valid.
 */

`timescale 1ns/10ps

module mul_unit
(
        input  logic                       i_clk,
        input  logic                       i_reset,
        input  logic                       i_stall,
        input  logic                       i_valid,
        input  logic [mul_pkg::OP_W-1:0]   i_op,
        input  logic [mul_pkg::WORD_W-1:0] i_rm,
        input  logic [mul_pkg::WORD_W-1:0] i_rs,
        input  logic [mul_pkg::WORD_W-1:0] i_rn,
        input  logic [mul_pkg::WORD_W-1:0] i_rh,

        output logic [mul_pkg::WORD_W-1:0] o_rd,
        output logic                       o_sat,
        output logic                       o_nozero,
        output logic                       o_busy,
        output logic                       o_done
);

logic signed [mul_pkg::PART_W-1:0] a, b, c, d;
logic signed [mul_pkg::PROD_W-1:0] ab, bc, ad, cd;
logic                              take_upper;
logic                              is_high;
logic                              is_mac;
logic                              is_mul;
logic                              step_lo;
logic                              step_hi;
logic                              step_out;

////////////////////////////////////////////////////////////

mul_operand_decode u_decode (
        .i_clk        (i_clk),
        .i_op         (i_op),
        .i_rm         (i_rm),
        .i_rs         (i_rs),
        .o_a          (a),
        .o_b          (b),
        .o_c          (c),
        .o_d          (d),
        .o_take_upper (take_upper),
        .o_is_high    (is_high),
        .o_is_mac     (is_mac),
        .o_is_mul     (is_mul)
);

mul_product_array u_products (
        .i_clk (i_clk),
        .i_a   (a),
        .i_b   (b),
        .i_c   (c),
        .i_d   (d),
        .o_ab  (ab),
        .o_bc  (bc),
        .o_ad  (ad),
        .o_cd  (cd)
);

mul_sequencer u_sequencer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_stall    (i_stall),
        .i_valid    (i_valid),
        .i_is_mul   (is_mul),
        .i_is_high  (is_high),
        .o_step_lo  (step_lo),
        .o_step_hi  (step_hi),
        .o_step_out (step_out),
        .o_busy     (o_busy)
);

// Output step is the done cycle
assign o_done = step_out;

mul_accumulate u_accumulate (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_stall      (i_stall),
        .i_step_lo    (step_lo),
        .i_step_hi    (step_hi),
        .i_step_out   (step_out),
        .i_is_high    (is_high),
        .i_is_mac     (is_mac),
        .i_take_upper (take_upper),
        .i_ab         (ab),
        .i_bc         (bc),
        .i_ad         (ad),
        .i_cd         (cd),
        .i_rn         (i_rn),
        .i_rh         (i_rh),
        .o_rd         (o_rd),
        .o_sat        (o_sat),
        .o_nozero     (o_nozero)
);

endmodule

// ==== dv/mul_checker.sv ====
/*
 * Result monitor for the multiply unit testbench.
 * Watches the DUT handshake, measures the latency of each
 * operation and compares the done-cycle outputs with the
 * expected values that the testbench hands over.
 */

`timescale 1ns/10ps

module mul_checker
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_valid,
        input  logic        i_busy,
        input  logic        i_done,
        input  logic [31:0] i_rd,
        input  logic        i_sat,
        input  logic        i_nozero,
        input  logic [31:0] i_exp_rd,
        input  logic        i_exp_sat,
        input  logic        i_exp_nozero,
        input  logic [7:0]  i_exp_latency,

        output logic [31:0] o_errors,
        output logic [31:0] o_checks
);

logic       pending = 1'b0;
logic [7:0] cycles  = 8'd0;
int         error_count = 0;
int         check_count = 0;

////////////////////////////////////////////////////////////

task automatic compare_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (exp_val !== act_val)
        begin
                $display("FAIL %s expected %h got %h", name, exp_val, act_val);
                error_count = error_count + 1;
        end
endtask

task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count = error_count + 1;
endtask

////////////////////////////////////////////////////////////

// Sampled on the rising edge, inputs move 1 ns later
always @(posedge i_clk)
begin
        if (i_reset)
        begin
                pending = 1'b0;
                cycles  = 8'd0;
        end
        else if (pending)
        begin
                cycles = cycles + 8'd1;
                if (i_done)
                begin
                        compare_field("o_rd", i_exp_rd, i_rd);
                        compare_field("o_sat", {31'd0, i_exp_sat}, {31'd0, i_sat});
                        compare_field("o_nozero", {31'd0, i_exp_nozero}, {31'd0, i_nozero});
                        compare_field("latency", {24'd0, i_exp_latency}, {24'd0, cycles});
                        if (i_busy)
                        begin
                                report_problem("o_busy was high in the done cycle");
                        end
                        check_count = check_count + 1;
                        pending     = 1'b0;
                end
                else if (!i_busy)
                begin
                        report_problem("o_busy dropped while an operation was in flight");
                end
        end
        else if (i_done)
        begin
                report_problem("o_done rose with no operation accepted");
        end
        else if (i_valid && !i_busy)
        begin
                // Accepted on this edge
                pending = 1'b1;
                cycles  = 8'd0;
        end
end

assign o_errors = error_count;
assign o_checks = check_count;

endmodule

// ==== dv/tb_mul_unit.sv ====
/*
 * Testbench for the multiply unit.
 * Reads vectors from the stimulus file, runs each one through
 * the valid/done handshake with optional stall cycles and
 * leaves the comparing to the checker.
 */

`timescale 1ns/10ps

module tb_mul_unit;

localparam int MAX_VEC = 32;
localparam int REC_W   = 180;
localparam int CLK_NS  = 8;
localparam int RST_CYC = 16;

logic             i_clk;
logic             i_reset;
logic             i_stall;
logic             i_valid;
logic [4:0]       i_op;
logic [31:0]      i_rm;
logic [31:0]      i_rs;
logic [31:0]      i_rn;
logic [31:0]      i_rh;
logic [31:0]      o_rd;
logic             o_sat;
logic             o_nozero;
logic             o_busy;
logic             o_done;

logic [REC_W-1:0] stim [0:MAX_VEC-1];
logic [31:0]      exp_rd;
logic             exp_sat;
logic             exp_nozero;
logic [7:0]       exp_latency;
logic [3:0]       stall_len;
logic [31:0]      errors;
logic [31:0]      checks;
int               vec_count;
int               max_stall;
int               limit_ns = 0;
int               total_errors;

mul_unit u_dut (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_stall  (i_stall),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_rm     (i_rm),
        .i_rs     (i_rs),
        .i_rn     (i_rn),
        .i_rh     (i_rh),
        .o_rd     (o_rd),
        .o_sat    (o_sat),
        .o_nozero (o_nozero),
        .o_busy   (o_busy),
        .o_done   (o_done)
);

mul_checker u_checker (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_busy        (o_busy),
        .i_done        (o_done),
        .i_rd          (o_rd),
        .i_sat         (o_sat),
        .i_nozero      (o_nozero),
        .i_exp_rd      (exp_rd),
        .i_exp_sat     (exp_sat),
        .i_exp_nozero  (exp_nozero),
        .i_exp_latency (exp_latency),
        .o_errors      (errors),
        .o_checks      (checks)
);

////////////////////////////////////////////////////////////

initial
begin
        i_clk = 1'b0;
        forever
        begin
                #(CLK_NS / 2) i_clk = ~i_clk;
        end
end

// Field layout op, rm, rs, rn, rh, rd, sat, nozero, stall
task automatic apply_vector(input logic [REC_W-1:0] rec);
        logic [4:0] op;

        op         = rec[176:172];
        i_op       = op;
        i_rm       = rec[171:140];
        i_rs       = rec[139:108];
        i_rn       = rec[107:76];
        i_rh       = rec[75:44];
        exp_rd     = rec[43:12];
        exp_sat    = rec[8];
        exp_nozero = rec[4];
        stall_len  = rec[3:0];
        if ((op == mul_pkg::OP_UMULL_HI) || (op == mul_pkg::OP_SMULL_HI))
        begin
                exp_latency = 8'd2 + {4'd0, stall_len};
        end
        else
        begin
                exp_latency = 8'd4 + {4'd0, stall_len};
        end
        i_valid = 1'b1;
endtask

initial
begin
        i_reset     = 1'b1;
        i_stall     = 1'b0;
        i_valid     = 1'b0;
        i_op        = mul_pkg::OP_NONE;
        i_rm        = 32'd0;
        i_rs        = 32'd0;
        i_rn        = 32'd0;
        i_rh        = 32'd0;
        exp_rd      = 32'd0;
        exp_sat     = 1'b0;
        exp_nozero  = 1'b0;
        exp_latency = 8'd0;
        stall_len   = 4'd0;

        $readmemh("dv/mul_stimulus.hex", stim);
        vec_count = 0;
        max_stall = 0;
        // A zero op field marks the end of the vectors
        while ((vec_count < MAX_VEC) && !$isunknown(stim[vec_count]) &&
               (stim[vec_count][179:172] != 8'h00))
        begin
                if (int'(stim[vec_count][3:0]) > max_stall)
                begin
                        max_stall = int'(stim[vec_count][3:0]);
                end
                vec_count = vec_count + 1;
        end

        // Room for every vector at the longest stall, plus reset and a little tail
        limit_ns = (vec_count * (4 + max_stall + 2) + RST_CYC + 4) * CLK_NS;

        repeat (RST_CYC) @(posedge i_clk);
        #1 i_reset = 1'b0;

        for (int i = 0; i < vec_count; i++)
        begin
                apply_vector(stim[i]);
                @(posedge i_clk);
                if (stall_len != 4'd0)
                begin
                        #1 i_stall = 1'b1;
                        repeat (int'(stall_len)) @(posedge i_clk);
                        #1 i_stall = 1'b0;
                end
                @(negedge i_clk);
                while (!o_done)
                begin
                        @(negedge i_clk);
                end
                @(posedge i_clk);
                #1 i_valid = 1'b0;
                @(posedge i_clk);
                #1;
        end

        repeat (2) @(posedge i_clk);

        total_errors = int'(errors);
        if (vec_count == 0)
        begin
                $display("No vectors were read from the stimulus file");
                total_errors = total_errors + 1;
        end
        if (int'(checks) != vec_count)
        begin
                $display("Only %0d of %0d results were seen", checks, vec_count);
                total_errors = total_errors + 1;
        end
        $display("Summary: %0d vectors, %0d results checked, %0d errors",
                 vec_count, checks, total_errors);
        if (total_errors == 0)
        begin
                $display("All checks passed");
        end
        else
        begin
                $display("Checks failed");
        end
        $finish;
end

////////////////////////////////////////////////////////////

// Watchdog
initial
begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Checks failed");
        $finish;
end

endmodule

// ==== src.f ====
src/mul_pkg.sv
src/mul_operand_decode.sv
src/mul_product_array.sv
src/mul_sequencer.sv
src/mul_accumulate.sv
src/mul_unit.sv
dv/mul_checker.sv
dv/tb_mul_unit.sv

// ==== Makefile ====
TOP = tb_mul_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)

run: build
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== dv/mul_stimulus.hex ====
// op_rm_rs_rn_rh_rd_sat_nozero_stall, one vector per line, all fields hex
// HI vectors reuse the operands of the LO vector just before them
01_00000003_00000005_00000000_00000000_0000000f_0_0_0
02_00000003_00000005_00000000_00000000_00000000_0_1_0
01_ffffffff_ffffffff_00000001_00000002_00000002_0_0_2
02_ffffffff_ffffffff_00000001_00000002_00000000_0_1_0
03_fffffffe_00000003_00000000_00000000_fffffffa_0_0_0
04_fffffffe_00000003_00000000_00000000_ffffffff_0_1_1
03_80000000_80000000_00000000_00000000_00000000_0_0_0
04_80000000_80000000_00000000_00000000_40000000_0_0_0
03_00010000_ffff0000_00000005_00000000_00000005_0_0_0
04_00010000_ffff0000_00000005_00000000_ffffffff_0_1_0
05_00000003_0000fffe_00000000_00000000_fffffffa_0_0_0
06_12340010_ffff5678_00000000_00000000_fffffff0_0_0_0
07_7fff0000_00007fff_00000000_00000000_3fff0001_0_0_1
08_80001234_80000000_00000000_00000000_40000000_0_0_0
09_00000002_00000003_00000004_00000000_0000000a_0_0_0
0a_00008000_7fff0000_80000000_00000000_40008000_1_0_3
0b_ffff0000_00000005_00000003_00000000_fffffffe_0_0_0
0c_80000000_80000000_40000000_00000000_80000000_1_0_0
0d_00010000_abcd0003_00000000_00000000_00000003_0_0_0
0e_12345678_00100000_00000000_00000000_00012345_0_0_0
0d_80000000_0000ffff_00000000_00000000_00008000_0_0_1
